// ==== dmem_consts.svh ====
// Sizes and fixed values of the banked data memory, included by every design file that needs them
`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// --------------------
// Address map
// --------------------

// Address that maps to byte 0 of the memory
`define DMEM_BASE_ADDR 32'h8000_2000

// --------------------
// Organization
// --------------------

// Words held by each byte bank, 8 KB in total
`define DMEM_DEPTH_WORDS 2048

// Bank address width, log2 of the depth
`define DMEM_WORD_AW 11

// Byte banks side by side, one per byte of a word
`define DMEM_LANES 4

// Load result for an illegal code or a misaligned address
`define DMEM_DEFAULT_WORD 32'hABCD_EF12

`endif

// ==== mem_op_pkg.sv ====
// Types of one RISC-V load or store request, shared by the memory and its testbench
package mem_op_pkg;

  // --------------------
  // fn3 codes
  // --------------------

  // Store widths, fn3 field of the S-type encoding
  typedef enum logic [2:0] {
    fn3_sb = 3'b000,
    fn3_sh = 3'b001,
    fn3_sw = 3'b010
  } store_fn3_e;

  // Load widths, fn3 field of the I-type load encoding
  // Codes 3, 6 and 7 are not legal loads
  typedef enum logic [2:0] {
    fn3_lb  = 3'b000,
    fn3_lh  = 3'b001,
    fn3_lw  = 3'b010,
    fn3_lbu = 3'b100,
    fn3_lhu = 3'b101
  } load_fn3_e;

  // Same three bits, read as a store code on a write
  // and as a load code otherwise
  typedef union packed {
    store_fn3_e st;
    load_fn3_e  ld;
  } mem_fn3_u;

  // --------------------
  // Request
  // --------------------

  // One access, valid for the single cycle req is high
  typedef struct packed {
    // Access strobe
    logic        req;
    // High for a store
    logic        wr_en;
    // Width and extension code
    mem_fn3_u    fn3;
    // Byte address, absolute
    logic [31:0] addr;
    // Store data, right aligned
    logic [31:0] wdata;
  } mem_req_s;

endpackage

// ==== dmem_pkg.sv ====
// Types of the banked memory organization, used between the steering, bank and load stages
package dmem_pkg;

  // --------------------
  // Bank write side
  // --------------------

  // Write of one byte bank for one cycle
  // data is already moved to the lane it belongs to
  typedef struct packed {
    // Byte write enable
    logic       we;
    // Byte for this lane
    logic [7:0] data;
  } lane_wr_s;

  // --------------------
  // Load stage
  // --------------------

  // A load in flight, formed at the request and
  // registered alongside the bank read
  typedef struct packed {
    // A load was requested
    logic                  valid;
    // Halfword or word not on its natural boundary
    logic                  misaligned;
    // Width and extension, may hold an illegal code
    mem_op_pkg::load_fn3_e fn3;
    // Byte offset inside the word, drives the right shift
    logic [1:0]            offset;
  } load_stage_s;

  // Width check
  // 1 valid + 1 misaligned + 3 fn3 + 2 offset = 7 bits

endpackage

// ==== store_lane_steer.sv ====
// Request decode stage that turns an access into per-bank byte writes, a bank address and a load record
`include "dmem_consts.svh"

module store_lane_steer (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  mem_op_pkg::mem_req_s                    req_in,
  output dmem_pkg::lane_wr_s [`DMEM_LANES-1:0]    lane_wr,
  output logic [`DMEM_WORD_AW-1:0]                bank_addr,
  output dmem_pkg::load_stage_s                   load_stage,
  output logic                                    misaligned
);

  import mem_op_pkg::*;

  // --------------------
  // Address split
  // --------------------

  logic [31:0]            byte_off;
  logic [1:0]             lane_off;
  logic                   is_store;
  logic                   is_load;
  logic                   acc_byte;
  logic                   acc_half;
  logic                   acc_word;
  logic                   mis_d;
  logic                   misaligned_q;
  logic [`DMEM_LANES-1:0] lane_mask;
  logic [31:0]            wdata_sh;

  // Offset from the base, upper bits drop out so the offset wraps
  assign byte_off  = req_in.addr - `DMEM_BASE_ADDR;
  assign bank_addr = byte_off[`DMEM_WORD_AW+1:2];
  assign lane_off  = byte_off[1:0];

  assign is_store = req_in.req & req_in.wr_en;
  assign is_load  = req_in.req & ~req_in.wr_en;

  // --------------------
  // fn3 decode
  // --------------------

  // Store codes on a write, load codes on a read
  always_comb begin
    acc_byte = 1'b0;
    acc_half = 1'b0;
    acc_word = 1'b0;
    if (req_in.wr_en) begin
      case (req_in.fn3.st)
        fn3_sb:  acc_byte = 1'b1;
        fn3_sh:  acc_half = 1'b1;
        fn3_sw:  acc_word = 1'b1;
        default: ;
      endcase
    end else begin
      case (req_in.fn3.ld)
        fn3_lb, fn3_lbu: acc_byte = 1'b1;
        fn3_lh, fn3_lhu: acc_half = 1'b1;
        fn3_lw:          acc_word = 1'b1;
        default:         ;
      endcase
    end
  end

  // Only alignment check in the design
  assign mis_d = req_in.req & ((acc_half & lane_off[0]) | (acc_word & (lane_off != 2'b00)));

  // --------------------
  // Store lanes
  // --------------------

  // Lanes touched, stays zero for an illegal code
  always_comb begin
    lane_mask = '0;
    if (acc_byte) lane_mask = `DMEM_LANES'(1) << lane_off;
    if (acc_half) lane_mask = `DMEM_LANES'(3) << lane_off;
    if (acc_word) lane_mask = '1;
  end

  // Move the low bytes of the store data up to the first lane used
  assign wdata_sh = req_in.wdata << {lane_off, 3'b000};

  always_comb begin
    for (int i = 0; i < `DMEM_LANES; i++) begin
      lane_wr[i].we   = is_store & ~mis_d & lane_mask[i];
      lane_wr[i].data = wdata_sh[8*i +: 8];
    end
  end

  // Flag for one cycle after any misaligned access
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      misaligned_q <= 1'b0;
    end else begin
      misaligned_q <= mis_d;
    end
  end

  assign misaligned = misaligned_q;

  // Load record, registered by the load stage with the bank read
  always_comb begin
    load_stage.valid      = is_load;
    load_stage.misaligned = mis_d;
    load_stage.fn3        = req_in.fn3.ld;
    load_stage.offset     = lane_off;
  end

endmodule

// ==== byte_bank.sv ====
// One byte lane of the data memory, a synchronous RAM with byte write and registered read
`include "dmem_consts.svh"

module byte_bank (
  input  logic                     clk,
  input  logic [`DMEM_WORD_AW-1:0] addr,
  input  dmem_pkg::lane_wr_s       wr,
  output logic [7:0]               rd_byte
);

  // --------------------
  // Storage
  // --------------------

  // One byte per word address, contents start undefined
  logic [7:0] mem [0:`DMEM_DEPTH_WORDS-1];

  // Read data register, loaded every cycle
  logic [7:0] rd_q;

  // --------------------
  // Access
  // --------------------

  // Write and read share the edge
  // the read sees the byte from before the write
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[addr] <= wr.data;
    end
    rd_q <= mem[addr];
  end

  // Valid one cycle after the address
  assign rd_byte = rd_q;

endmodule

// ==== load_extend.sv ====
// Load result stage that joins the bank bytes, aligns them and applies sign or zero extension
`include "dmem_consts.svh"

module load_extend (
  input  logic                               clk,
  input  logic                               rst_n,
  input  dmem_pkg::load_stage_s              load_stage,
  input  logic [`DMEM_LANES-1:0][7:0]        bank_bytes,
  output logic [31:0]                        rdata,
  output logic                               rdata_valid
);

  import mem_op_pkg::*;
  import dmem_pkg::*;

  // --------------------
  // Stage register
  // --------------------

  // Load record of the access whose bytes are now out of the banks
  load_stage_s stage_q;

  logic [31:0] word_raw;
  logic [31:0] word_sh;
  logic [31:0] load_res;
  logic [31:0] rdata_q;

  // Same edge as the bank read register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= '0;
    end else begin
      stage_q <= load_stage;
    end
  end

  // --------------------
  // Align and extend
  // --------------------

  // Lane 0 is the lowest byte
  assign word_raw = bank_bytes;

  // Addressed byte or halfword moves down to bit 0
  assign word_sh = word_raw >> {stage_q.offset, 3'b000};

  always_comb begin
    load_res = `DMEM_DEFAULT_WORD;
    if (!stage_q.misaligned) begin
      case (stage_q.fn3)
        // Signed byte
        fn3_lb:  load_res = {{24{word_sh[7]}}, word_sh[7:0]};
        // Signed halfword
        fn3_lh:  load_res = {{16{word_sh[15]}}, word_sh[15:0]};
        // Full word, offset is always zero here
        fn3_lw:  load_res = word_raw;
        // Unsigned byte
        fn3_lbu: load_res = {24'h00_0000, word_sh[7:0]};
        // Unsigned halfword
        fn3_lhu: load_res = {16'h0000, word_sh[15:0]};
        // Illegal load code
        default: load_res = `DMEM_DEFAULT_WORD;
      endcase
    end
  end

  // --------------------
  // Output hold
  // --------------------

  // Keeps the last result while no load completes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (stage_q.valid) begin
      rdata_q <= load_res;
    end
  end

  // New result goes out in its own cycle, the held one otherwise
  assign rdata       = stage_q.valid ? load_res : rdata_q;
  assign rdata_valid = stage_q.valid;

endmodule

// ==== data_mem.sv ====
// Top of the RV32 data memory, with request decode, four byte banks and the load result stage
`include "dmem_consts.svh"

module data_mem (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mem_op_pkg::mem_req_s req_in,
  output logic [31:0]          rdata,
  output logic                 rdata_valid,
  output logic                 misaligned
);

  import dmem_pkg::*;

  // --------------------
  // Internal wires
  // --------------------

  // Byte writes, one per bank
  lane_wr_s [`DMEM_LANES-1:0]  lane_wr;

  // Word address shared by all banks
  logic [`DMEM_WORD_AW-1:0]    bank_addr;

  // Load record toward the result stage
  load_stage_s                 load_stage;

  // Registered bytes out of the banks, lane 0 lowest
  logic [`DMEM_LANES-1:0][7:0] bank_bytes;

  // --------------------
  // Request decode
  // --------------------

  store_lane_steer i_store_lane_steer (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_in     (req_in),
    .lane_wr    (lane_wr),
    .bank_addr  (bank_addr),
    .load_stage (load_stage),
    .misaligned (misaligned)
  );

  // --------------------
  // Byte banks
  // --------------------

  // Each bank holds one byte position of every word
  for (genvar g = 0; g < `DMEM_LANES; g++) begin : g_bank
    byte_bank i_byte_bank (
      .clk     (clk),
      .addr    (bank_addr),
      .wr      (lane_wr[g]),
      .rd_byte (bank_bytes[g])
    );
  end

  // --------------------
  // Load result
  // --------------------

  load_extend i_load_extend (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_stage  (load_stage),
    .bank_bytes  (bank_bytes),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

endmodule

// ==== tb_data_mem_tasks.svh ====
// Directed tests with their drive and check helpers, included in the testbench module body
`ifndef TB_DATA_MEM_TASKS_SVH
`define TB_DATA_MEM_TASKS_SVH

  // --------------------
  // Drive and check
  // --------------------

  // Stops the run at the first mismatch
  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Request is sampled at the following rising edge
  task automatic send_req(input logic wr, input logic [2:0] code,
                          input logic [31:0] addr, input logic [31:0] wdata);
    mem_req_s r;
    r       = '0;
    r.req   = 1'b1;
    r.wr_en = wr;
    r.addr  = addr;
    r.wdata = wdata;
    // Same fn3 bits, typed by the access kind
    if (wr) begin
      r.fn3.st = store_fn3_e'(code);
    end else begin
      r.fn3.ld = load_fn3_e'(code);
    end
    @(posedge clk);
    req_in <= r;
  endtask

  task automatic go_idle();
    @(posedge clk);
    req_in <= '0;
  endtask

  // Polls at the falling edge, counts cycles after the sampling edge
  task automatic wait_result(input string name, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!rdata_valid && cycles < TIMEOUT_CYC);
    assert (rdata_valid) else begin
      $display("%s: no load result after %0d cycles", name, TIMEOUT_CYC);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  endtask

  task automatic do_store(input string name, input logic [2:0] code,
                          input logic [31:0] addr, input logic [31:0] data);
    logic [12:0] idx;
    idx = byte_index(addr);
    send_req(1'b1, code, addr, data);
    go_idle();
    model_store(addr, code, data);
    @(negedge clk);
    check_eq({name, " misaligned"}, {31'd0, exp_misaligned(1'b1, code, idx[1:0])},
             {31'd0, misaligned});
  endtask

  task automatic do_load_check(input string name, input logic [2:0] code,
                               input logic [31:0] addr);
    logic [12:0] idx;
    logic [31:0] exp_val;
    int          cycles;
    idx     = byte_index(addr);
    exp_val = exp_load(addr, code);
    send_req(1'b0, code, addr, 32'h0);
    go_idle();
    wait_result(name, cycles);
    check_eq({name, " latency"}, 32'd1, cycles);
    check_eq(name, exp_val, rdata);
    check_eq({name, " misaligned"}, {31'd0, exp_misaligned(1'b0, code, idx[1:0])},
             {31'd0, misaligned});
    // Idle cycle after the result, valid drops and rdata holds
    @(negedge clk);
    check_eq({name, " valid pulse"}, 32'd0, {31'd0, rdata_valid});
    check_eq({name, " hold"}, exp_val, rdata);
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic check_after_reset();
    int cycles;
    @(negedge clk);
    check_eq("reset rdata_valid", 32'd0, {31'd0, rdata_valid});
    check_eq("reset misaligned", 32'd0, {31'd0, misaligned});
    check_eq("reset rdata", 32'd0, rdata);
    do_store("first sw", fn3_sw, `DMEM_BASE_ADDR + 32'h40, 32'h1357_9BDF);
    // No result before the load is sampled
    send_req(1'b0, fn3_lw, `DMEM_BASE_ADDR + 32'h40, 32'h0);
    @(negedge clk);
    check_eq("first load early valid", 32'd0, {31'd0, rdata_valid});
    go_idle();
    wait_result("first load", cycles);
    check_eq("first load latency", 32'd1, cycles);
    check_eq("first load data", 32'h1357_9BDF, rdata);
  endtask

  task automatic word_round_trip();
    logic [31:0] addrs [8];
    for (int i = 0; i < 8; i++) begin
      // Any aligned address, the offset wraps into the memory
      addrs[i] = $urandom & 32'hFFFF_FFFC;
      do_store($sformatf("word sw %0d", i), fn3_sw, addrs[i], $urandom);
    end
    for (int i = 0; i < 8; i++) begin
      do_load_check($sformatf("word lw %0d", i), fn3_lw, addrs[i]);
    end
  endtask

  task automatic lane_writes();
    logic [31:0] base;
    base = `DMEM_BASE_ADDR + 32'h100;
    for (int off = 0; off < 4; off++) begin
      do_store("lanes sw", fn3_sw, base, $urandom);
      do_store("lanes sb", fn3_sb, base + off, $urandom);
      do_load_check($sformatf("lanes sb off %0d", off), fn3_lw, base);
    end
    for (int off = 0; off < 4; off += 2) begin
      do_store("lanes sw", fn3_sw, base, $urandom);
      do_store("lanes sh", fn3_sh, base + off, $urandom);
      do_load_check($sformatf("lanes sh off %0d", off), fn3_lw, base);
    end
  endtask

  task automatic load_extension();
    logic [31:0] words [2];
    logic [31:0] base;
    // Every byte and halfword position has its top bit set in one word only
    words[0] = 32'h9A7B_E615;
    words[1] = 32'h25C4_6DF8;
    base     = `DMEM_BASE_ADDR + 32'h200;
    for (int w = 0; w < 2; w++) begin
      do_store("extend sw", fn3_sw, base, words[w]);
      for (int off = 0; off < 4; off++) begin
        do_load_check($sformatf("lb w%0d off %0d", w, off), fn3_lb, base + off);
        do_load_check($sformatf("lbu w%0d off %0d", w, off), fn3_lbu, base + off);
      end
      for (int off = 0; off < 4; off += 2) begin
        do_load_check($sformatf("lh w%0d off %0d", w, off), fn3_lh, base + off);
        do_load_check($sformatf("lhu w%0d off %0d", w, off), fn3_lhu, base + off);
      end
    end
  endtask

  task automatic misaligned_access();
    logic [31:0] base;
    base = `DMEM_BASE_ADDR + 32'h300;
    do_store("mis init sw", fn3_sw, base, 32'h0F1E_2D3C);
    for (int off = 1; off < 4; off++) begin
      do_store($sformatf("mis sw off %0d", off), fn3_sw, base + off, 32'hDEAD_BEEF);
      // Flag lasts a single cycle
      @(negedge clk);
      check_eq("mis flag cleared", 32'd0, {31'd0, misaligned});
      if (off != 2) begin
        do_store($sformatf("mis sh off %0d", off), fn3_sh, base + off, 32'h0000_5A5A);
        do_load_check($sformatf("mis lh off %0d", off), fn3_lh, base + off);
        do_load_check($sformatf("mis lhu off %0d", off), fn3_lhu, base + off);
      end
      do_load_check($sformatf("mis lw off %0d", off), fn3_lw, base + off);
    end
    do_load_check("mis word unchanged", fn3_lw, base);
    // Code 3 is neither a store nor a load, 6 and 7 are no loads
    do_store("bad store code", 3'b011, base, 32'h7777_7777);
    do_load_check("bad store unchanged", fn3_lw, base);
    do_load_check("bad load code 3", 3'b011, base);
    do_load_check("bad load code 6", 3'b110, base);
    do_load_check("bad load code 7", 3'b111, base);
  endtask

  task automatic back_to_back();
    logic [31:0] addr;
    logic [31:0] data;
    logic [2:0]  codes [6];
    logic [31:0] offs [6];
    logic [31:0] exp_vals [6];
    int          cycles;
    addr = `DMEM_BASE_ADDR + 32'h400;
    data = $urandom;
    // Load of the same word right after the store
    send_req(1'b1, fn3_sw, addr, data);
    send_req(1'b0, fn3_lw, addr, 32'h0);
    go_idle();
    model_store(addr, fn3_sw, data);
    wait_result("store then load", cycles);
    check_eq("store then load latency", 32'd1, cycles);
    check_eq("store then load", data, rdata);
    for (int i = 0; i < 6; i++) begin
      do_store("burst sw", fn3_sw, addr + 32'(4 * i), $urandom);
    end
    codes = '{fn3_lw, fn3_lb, fn3_lhu, fn3_lbu, fn3_lh, fn3_lw};
    offs  = '{0, 3, 2, 1, 2, 0};
    for (int i = 0; i < 6; i++) begin
      exp_vals[i] = exp_load(addr + 32'(4 * i) + offs[i], codes[i]);
    end
    // One load per cycle, each result one cycle after its request
    for (int i = 0; i <= 6; i++) begin
      if (i < 6) begin
        send_req(1'b0, codes[i], addr + 32'(4 * i) + offs[i], 32'h0);
      end else begin
        go_idle();
      end
      if (i > 0) begin
        @(negedge clk);
        check_eq($sformatf("burst valid %0d", i - 1), 32'd1, {31'd0, rdata_valid});
        check_eq($sformatf("burst load %0d", i - 1), exp_vals[i - 1], rdata);
      end
    end
  endtask

`endif

// ==== tb_data_mem.sv ====
// Testbench top for the data memory, with clock, reset, DUT, byte model and the test order
`include "dmem_consts.svh"

module tb_data_mem;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_op_pkg::*;

  // --------------------
  // Setup
  // --------------------

  localparam logic [31:0] SEED        = 32'h6968_d937;
  localparam int          MEM_BYTES   = `DMEM_DEPTH_WORDS * `DMEM_LANES;
  localparam int          TIMEOUT_CYC = 20;

  logic        clk;
  logic        rst_n;
  mem_req_s    req_in;
  logic [31:0] rdata;
  logic        rdata_valid;
  logic        misaligned;

  // Byte image of the memory, changed only by accepted stores
  logic [7:0] model_mem [0:MEM_BYTES-1];

  // 4 ns period
  always #2 clk = ~clk;

  data_mem i_data_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_in      (req_in),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .misaligned  (misaligned)
  );

  // --------------------
  // Reference model
  // --------------------

  // Offset from the base, modulo the 8 KB size
  function automatic logic [12:0] byte_index(input logic [31:0] addr);
    logic [31:0] diff;
    diff = addr - `DMEM_BASE_ADDR;
    return diff[12:0];
  endfunction

  // Halfword needs an even offset, word needs offset zero
  function automatic logic exp_misaligned(input logic wr, input logic [2:0] code,
                                          input logic [1:0] off);
    logic half;
    logic word;
    half = wr ? (code == fn3_sh) : (code == fn3_lh || code == fn3_lhu);
    word = wr ? (code == fn3_sw) : (code == fn3_lw);
    return (half && off[0]) || (word && off != 2'b00);
  endfunction

  // Expected load result from the byte image
  function automatic logic [31:0] exp_load(input logic [31:0] addr, input logic [2:0] code);
    logic [12:0] idx;
    logic [7:0]  b;
    logic [15:0] h;
    idx = byte_index(addr);
    b   = model_mem[idx];
    h   = {model_mem[idx + 13'd1], b};
    if (exp_misaligned(1'b0, code, idx[1:0])) begin
      return `DMEM_DEFAULT_WORD;
    end
    case (code)
      fn3_lb:  return {{24{b[7]}}, b};
      fn3_lh:  return {{16{h[15]}}, h};
      fn3_lw:  return {model_mem[idx + 13'd3], model_mem[idx + 13'd2], h};
      fn3_lbu: return {24'h00_0000, b};
      fn3_lhu: return {16'h0000, h};
      // Codes 3, 6 and 7
      default: return `DMEM_DEFAULT_WORD;
    endcase
  endfunction

  // Dropped when misaligned or not a store code
  function automatic void model_store(input logic [31:0] addr, input logic [2:0] code,
                                      input logic [31:0] data);
    logic [12:0] idx;
    idx = byte_index(addr);
    if (!exp_misaligned(1'b1, code, idx[1:0])) begin
      case (code)
        fn3_sb: model_mem[idx] = data[7:0];
        fn3_sh: begin
          model_mem[idx]         = data[7:0];
          model_mem[idx + 13'd1] = data[15:8];
        end
        fn3_sw: begin
          for (int i = 0; i < 4; i++) begin
            model_mem[idx + 13'(i)] = data[8*i +: 8];
          end
        end
        default: ;
      endcase
    end
  endfunction

  `include "tb_data_mem_tasks.svh"

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    int unsigned seed_ret;
    clk    = 1'b0;
    rst_n  = 1'b0;
    req_in = '0;
    // One seed for the whole run
    seed_ret = $urandom(SEED);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    check_after_reset();
    word_round_trip();
    lane_writes();
    load_extension();
    misaligned_access();
    back_to_back();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
mem_op_pkg.sv
dmem_pkg.sv
store_lane_steer.sv
byte_bank.sv
load_extend.sv
data_mem.sv
tb_data_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the data memory testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_data_mem \
  -f compile.f \
  -o sim_data_mem

# A failing run exits with an error status, the log is searched afterwards
if ./obj_dir/sim_data_mem > sim.log 2>&1; then
  sim_status=0
else
  sim_status=1
fi
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if [ "$sim_status" -ne 0 ] || ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation did not complete"
  exit 1
fi
echo "Simulation passed"
